/* project.f */
src/sd_pkg.sv
src/sd_if.sv
src/sd_clk_gen.sv
src/sd_cmd_tx.sv
src/sd_resp_rx.sv
src/sd_init_seq.sv
src/sd_init_top.sv
tb/sd_card_model.sv
tb/tb_sd_init.sv

/* src/sd_clk_gen.sv */
// SD clock divider, sd_clk toggles every CLK_DIV system clocks
// edge strobes are one system clock wide and coincide with the toggle
// all SD logic stays in the system clock domain
`timescale 1ns/1ns

module sd_clk_gen #(
    parameter int CLK_DIV = 250
) (
    input  logic clk,
    input  logic rst_n,
    output logic sd_clk,
    output logic sd_rise,
    output logic sd_fall
);

    localparam int CW = $clog2(CLK_DIV + 1);

    logic [CW-1:0] div_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sd_clk  <= 1'b0;
            sd_rise <= 1'b0;
            sd_fall <= 1'b0;
        end else begin
            sd_rise <= 1'b0;
            sd_fall <= 1'b0;
            if (div_cnt == CW'(CLK_DIV - 1)) begin
                div_cnt <= '0;
                sd_clk  <= ~sd_clk;
                // strobe marks the edge being made now
                sd_rise <= ~sd_clk;
                sd_fall <= sd_clk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // tx shifts on falls, rx samples on rises, never both at once
    assert property (@(posedge clk) disable iff (!rst_n) !(sd_rise && sd_fall));

endmodule

/* src/sd_cmd_tx.sv */
// CMD line transmitter, one 48-bit command per start
// bits go out MSB first, one per SD clock fall
// CMD is driven high from the first fall after reset until the first command,
// which gives the power-up idle clocks; after each command the line is released
`timescale 1ns/1ns

module sd_cmd_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sd_fall,
    sd_cmd_if.slave    cmd,
    output logic       cmd_out,
    output logic       cmd_oe
);

    logic [39:0] frame_head;
    logic [47:0] frame;
    logic [47:0] shreg;
    logic [5:0]  bit_cnt;
    logic        preamble;

    // start 0, direction 1 (host), index, argument
    assign frame_head = {1'b0, 1'b1, cmd.index, cmd.arg};
    assign frame      = {frame_head, sd_pkg::crc7(frame_head), 1'b1};

    // ========================================
    // control
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd.busy <= 1'b0;
            cmd.done <= 1'b0;
            cmd_oe   <= 1'b0;
            cmd_out  <= 1'b1;
            bit_cnt  <= '0;
            preamble <= 1'b1;
        end else begin
            cmd.done <= 1'b0;
            if (cmd.start && !cmd.busy) begin
                // first bit waits for the next fall
                cmd.busy <= 1'b1;
                preamble <= 1'b0;
                bit_cnt  <= '0;
            end else if (sd_fall) begin
                if (cmd.busy) begin
                    if (bit_cnt == 6'd48) begin
                        // fall after the end bit
                        cmd_oe   <= 1'b0;
                        cmd_out  <= 1'b1;
                        cmd.busy <= 1'b0;
                        cmd.done <= 1'b1;
                    end else begin
                        cmd_oe  <= 1'b1;
                        cmd_out <= shreg[47];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end else if (preamble) begin
                    // idle high before CMD0
                    cmd_oe  <= 1'b1;
                    cmd_out <= 1'b1;
                end
            end
        end
    end

    // ========================================
    // frame shifter
    // ========================================
    always_ff @(posedge clk) begin
        if (cmd.start && !cmd.busy)
            shreg <= frame;
        else if (sd_fall && cmd.busy && bit_cnt != 6'd48)
            shreg <= {shreg[46:0], 1'b1};
    end

    // sequencer keeps to the busy rule
    assert property (@(posedge clk) disable iff (!rst_n) cmd.start |-> !cmd.busy);

endmodule

/* src/sd_if.sv */
// command and response links between the sequencer and the CMD line blocks
// plain strobes and levels, no handshake beyond busy
`timescale 1ns/1ns

// ========================================
// command request
// ========================================
interface sd_cmd_if;
    // start is a one-cycle pulse, index and arg sampled with it
    logic                  start;
    sd_pkg::cmd_index_t    index;
    logic [31:0]           arg;
    // busy from accepted start until done
    logic                  busy;
    logic                  done;

    modport master (
        output start, index, arg,
        input  busy, done
    );

    modport slave (
        input  start, index, arg,
        output busy, done
    );
endinterface

// ========================================
// response capture
// ========================================
interface sd_resp_if;
    logic                  arm;
    // exactly one of these per arm
    logic                  valid;
    logic                  timeout;
    // kept until the next arm
    sd_pkg::sd_resp_u      resp;

    modport master (
        output arm,
        input  valid, timeout, resp
    );

    modport slave (
        input  arm,
        output valid, timeout, resp
    );
endinterface

/* src/sd_init_seq.sv */
// SD power-up sequencer: idle clocks, CMD0, then CMD55/ACMD41 until ready
// status goes out as single ASCII characters with a one-cycle strobe
// the consumer must take every strobe, they are at least one SD clock apart
// stops for good on done or on the first error, a new reset restarts
`timescale 1ns/1ns

module sd_init_seq #(
    parameter int MAX_RETRIES = 100
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sd_fall,
    sd_cmd_if.master             cmd,
    sd_resp_if.master            resp,
    output sd_pkg::status_char_t char_data,
    output logic                 char_valid,
    output logic                 init_done,
    output logic                 init_error,
    output logic [31:0]          ocr
);

    localparam int RW = $clog2(MAX_RETRIES + 1);

    localparam logic [2:0] ST_PRE     = 3'd0;
    localparam logic [2:0] ST_SEND    = 3'd1;
    localparam logic [2:0] ST_TX_WAIT = 3'd2;
    localparam logic [2:0] ST_GAP     = 3'd3;
    localparam logic [2:0] ST_RX_WAIT = 3'd4;
    localparam logic [2:0] ST_VERDICT = 3'd5;
    localparam logic [2:0] ST_HALT    = 3'd6;

    logic [2:0]    state;
    // SD fall counter for idle clocks, CMD0 gap and strobe spacing
    logic [6:0]    fall_cnt;
    logic [RW-1:0] retry_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_PRE;
            fall_cnt   <= '0;
            retry_cnt  <= '0;
            cmd.start  <= 1'b0;
            cmd.index  <= sd_pkg::CMD0_GO_IDLE;
            cmd.arg    <= '0;
            resp.arm   <= 1'b0;
            char_data  <= '0;
            char_valid <= 1'b0;
            init_done  <= 1'b0;
            init_error <= 1'b0;
            ocr        <= '0;
        end else begin
            cmd.start  <= 1'b0;
            resp.arm   <= 1'b0;
            char_valid <= 1'b0;
            case (state)
                // ========================================
                // power-up, 80 clocks with CMD high
                // ========================================
                ST_PRE: if (sd_fall) begin
                    fall_cnt <= fall_cnt + 1'b1;
                    if (fall_cnt == 7'd79) begin
                        cmd.index <= sd_pkg::CMD0_GO_IDLE;
                        cmd.arg   <= '0;
                        state     <= ST_SEND;
                    end
                end
                ST_SEND: if (!cmd.busy) begin
                    cmd.start <= 1'b1;
                    state     <= ST_TX_WAIT;
                end
                ST_TX_WAIT: if (cmd.done) begin
                    fall_cnt <= '0;
                    // CMD0 has no response
                    if (cmd.index == sd_pkg::CMD0_GO_IDLE) begin
                        state <= ST_GAP;
                    end else begin
                        resp.arm <= 1'b1;
                        state    <= ST_RX_WAIT;
                    end
                end
                ST_GAP: if (sd_fall) begin
                    fall_cnt <= fall_cnt + 1'b1;
                    if (fall_cnt == 7'd15) begin
                        char_data  <= sd_pkg::CH_CMD0;
                        char_valid <= 1'b1;
                        cmd.index  <= sd_pkg::CMD55_APP;
                        cmd.arg    <= '0;
                        state      <= ST_SEND;
                    end
                end
                // ========================================
                // response decode, R1 after CMD55, R3 after ACMD41
                // ========================================
                ST_RX_WAIT: begin
                    if (resp.timeout) begin
                        char_data  <= sd_pkg::CH_TIMEOUT;
                        char_valid <= 1'b1;
                        init_error <= 1'b1;
                        state      <= ST_HALT;
                    end else if (resp.valid) begin
                        char_valid <= 1'b1;
                        if (cmd.index == sd_pkg::CMD55_APP &&
                            resp.resp.r1.index == sd_pkg::CMD55_APP) begin
                            char_data <= sd_pkg::CH_CMD55;
                            cmd.index <= sd_pkg::ACMD41_OP_COND;
                            cmd.arg   <= sd_pkg::ACMD41_ARG;
                            state     <= ST_SEND;
                        end else if (cmd.index == sd_pkg::ACMD41_OP_COND &&
                                     resp.resp.r3.rsvd == 6'h3f) begin
                            // ready or not is decided a clock later
                            char_data <= sd_pkg::CH_ACMD41;
                            state     <= ST_VERDICT;
                        end else begin
                            char_data  <= sd_pkg::CH_BAD_RESP;
                            init_error <= 1'b1;
                            state      <= ST_HALT;
                        end
                    end
                end
                // OCR is still held by the receiver here
                ST_VERDICT: if (sd_fall) begin
                    fall_cnt <= fall_cnt + 1'b1;
                    if (fall_cnt == 7'd1) begin
                        if (resp.resp.r3.ocr[sd_pkg::OCR_READY_BIT]) begin
                            char_data  <= sd_pkg::CH_DONE;
                            char_valid <= 1'b1;
                            init_done  <= 1'b1;
                            ocr        <= resp.resp.r3.ocr;
                            state      <= ST_HALT;
                        end else if (retry_cnt == RW'(MAX_RETRIES - 1)) begin
                            char_data  <= sd_pkg::CH_RETRY_LIMIT;
                            char_valid <= 1'b1;
                            init_error <= 1'b1;
                            state      <= ST_HALT;
                        end else begin
                            // card busy, next CMD55/ACMD41 pair
                            retry_cnt <= retry_cnt + 1'b1;
                            cmd.index <= sd_pkg::CMD55_APP;
                            cmd.arg   <= '0;
                            state     <= ST_SEND;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(init_done && init_error));

endmodule

/* src/sd_init_top.sv */
// SD card initializer, native SD mode, one-bit CMD line only
// CMD comes as out, output enable and in; the pad and CS/DAT3 belong to the board
// defaults give a 100 kHz SD clock from 50 MHz
`timescale 1ns/1ns

module sd_init_top #(
    parameter int CLK_DIV      = 250,
    parameter int RESP_TIMEOUT = 64,
    parameter int MAX_RETRIES  = 100
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_in,
    output logic        sd_clk,
    output logic        cmd_out,
    output logic        cmd_oe,
    output logic        char_valid,
    output logic        init_done,
    output logic        init_error,
    output logic [7:0]  char_data,
    output logic [31:0] ocr
);

    logic sd_rise;
    logic sd_fall;

    sd_cmd_if  cmd_bus ();
    sd_resp_if resp_bus ();

    sd_clk_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_clk_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .sd_clk  (sd_clk),
        .sd_rise (sd_rise),
        .sd_fall (sd_fall)
    );

    sd_cmd_tx u_cmd_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .sd_fall (sd_fall),
        .cmd     (cmd_bus.slave),
        .cmd_out (cmd_out),
        .cmd_oe  (cmd_oe)
    );

    sd_resp_rx #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) u_resp_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .sd_rise (sd_rise),
        .cmd_in  (cmd_in),
        .resp    (resp_bus.slave)
    );

    sd_init_seq #(
        .MAX_RETRIES (MAX_RETRIES)
    ) u_init_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .sd_fall    (sd_fall),
        .cmd        (cmd_bus.master),
        .resp       (resp_bus.master),
        .char_data  (char_data),
        .char_valid (char_valid),
        .init_done  (init_done),
        .init_error (init_error),
        .ocr        (ocr)
    );

endmodule

/* src/sd_pkg.sv */
// shared SD definitions for the native-mode initializer and its testbench
// command frames are 48 bits, MSB first, CRC7 over the first 40 bits
// only CMD0, CMD55 and ACMD41 are known here
// status characters double as the error codes of the sequence
package sd_pkg;

    // ========================================
    // commands
    // ========================================
    typedef logic [5:0] cmd_index_t;

    localparam cmd_index_t CMD0_GO_IDLE   = 6'd0;
    localparam cmd_index_t CMD55_APP      = 6'd55;
    localparam cmd_index_t ACMD41_OP_COND = 6'd41;

    // host capacity support, no voltage window
    localparam logic [31:0] ACMD41_ARG = 32'h4000_0000;

    // ========================================
    // responses
    // ========================================
    // one received frame, read as R1 or R3 by the command that was sent
    typedef union packed {
        struct packed {
            logic        start_bit;
            logic        dir;
            cmd_index_t  index;
            logic [31:0] status;
            logic [6:0]  crc;
            logic        end_bit;
        } r1;
        struct packed {
            logic        start_bit;
            logic        dir;
            logic [5:0]  rsvd;
            logic [31:0] ocr;
            logic [6:0]  ones;
            logic        end_bit;
        } r3;
    } sd_resp_u;

    localparam int R1_IDLE_BIT   = 0;
    localparam int OCR_READY_BIT = 31;

    // ========================================
    // status characters
    // ========================================
    typedef logic [7:0] status_char_t;

    localparam status_char_t CH_CMD0        = "0";
    localparam status_char_t CH_CMD55       = "5";
    localparam status_char_t CH_ACMD41      = "A";
    localparam status_char_t CH_DONE        = "D";
    // error codes
    localparam status_char_t CH_TIMEOUT     = "T";
    localparam status_char_t CH_RETRY_LIMIT = "E";
    localparam status_char_t CH_BAD_RESP    = "R";

    // CRC7, polynomial x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            fb  = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb)
                crc = crc ^ 7'h09;
        end
        return crc;
    endfunction

endpackage

/* src/sd_resp_rx.sv */
// CMD line receiver for 48-bit responses (R1, R3)
// hunts for a start bit after each arm, sampling on SD clock rises
// no CRC check on the response, the sequencer decodes the fields
// timeout after RESP_TIMEOUT rises without a start bit
`timescale 1ns/1ns

module sd_resp_rx #(
    parameter int RESP_TIMEOUT = 64
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sd_rise,
    input  logic       cmd_in,
    sd_resp_if.slave   resp
);

    localparam int TW = $clog2(RESP_TIMEOUT + 1);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_HUNT = 2'd1;
    localparam logic [1:0] ST_CAPT = 2'd2;

    logic [1:0]    state;
    logic [TW-1:0] wait_cnt;
    logic [5:0]    bit_cnt;
    logic [47:0]   shreg;

    // ========================================
    // control
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            wait_cnt     <= '0;
            bit_cnt      <= '0;
            resp.valid   <= 1'b0;
            resp.timeout <= 1'b0;
        end else begin
            resp.valid   <= 1'b0;
            resp.timeout <= 1'b0;
            if (resp.arm) begin
                state    <= ST_HUNT;
                wait_cnt <= '0;
            end else if (sd_rise) begin
                case (state)
                    ST_HUNT: begin
                        if (!cmd_in) begin
                            // start bit is bit 1 of 48
                            state   <= ST_CAPT;
                            bit_cnt <= 6'd1;
                        end else if (wait_cnt == TW'(RESP_TIMEOUT - 1)) begin
                            resp.timeout <= 1'b1;
                            state        <= ST_IDLE;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                    ST_CAPT: begin
                        if (bit_cnt == 6'd47) begin
                            resp.valid <= 1'b1;
                            state      <= ST_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // ========================================
    // capture
    // ========================================
    // idle ones shift through while hunting, start bit lands at the MSB
    always_ff @(posedge clk) begin
        if (sd_rise && state != ST_IDLE)
            shreg <= {shreg[46:0], cmd_in};
        if (sd_rise && state == ST_CAPT && bit_cnt == 6'd47)
            resp.resp <= {shreg[46:0], cmd_in};
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(resp.valid && resp.timeout));

endmodule

/* tb/sd_card_model.sv */
// behavioural SD card on the CMD line, native mode, no DAT lines
// knows CMD0, CMD55 and ACMD41 only; anything else gets no answer
// answers 2 to 8 SD clocks after the command end bit
// CMD0 returns the card to idle and restarts the busy count
`timescale 1ns/1ns

module sd_card_model #(
    parameter logic [31:0] READY_OCR = 32'hc0ff_8000
) (
    input  logic        sd_clk,
    input  logic        cmd_out,
    input  logic        cmd_oe,
    input  int          busy_count,
    input  logic        silent,
    output logic        cmd_in,
    output logic [47:0] last_cmd,
    output logic        cmd_toggle,
    output logic        crc_error
);

    // power-up still running, bit 31 clear
    localparam logic [31:0] BUSY_OCR  = READY_OCR & 32'h7fff_ffff;
    // app command accepted, card in idle state
    localparam logic [31:0] R1_STATUS = 32'h0000_0021;

    integer      seed;
    int          delay;
    int          acmd41_cnt;
    logic        answer;
    logic [47:0] frame;
    logic [47:0] reply;
    logic [39:0] head;

    initial begin
        seed       = 32'hf512_54f2;
        cmd_in     = 1'b1;
        last_cmd   = '0;
        cmd_toggle = 1'b0;
        crc_error  = 1'b0;
        acmd41_cnt = 0;
        forever begin
            @(posedge sd_clk);
            if (cmd_oe && !cmd_out) begin
                // ========================================
                // command capture, start bit already seen
                // ========================================
                frame     = '0;
                for (int i = 46; i >= 0; i--) begin
                    @(posedge sd_clk);
                    frame[i] = cmd_out;
                end
                last_cmd   = frame;
                cmd_toggle = ~cmd_toggle;
                if (frame[7:1] != sd_pkg::crc7(frame[47:8]) || !frame[46] || !frame[0]) begin
                    crc_error = 1'b1;
                    $display("card model: bad CRC7 or framing in command %0d", frame[45:40]);
                end

                // ========================================
                // decode and build the response
                // ========================================
                answer = 1'b0;
                if (frame[45:40] == sd_pkg::CMD0_GO_IDLE) begin
                    acmd41_cnt = 0;
                end else if (!silent && frame[45:40] == sd_pkg::CMD55_APP) begin
                    // R1 echoes the index
                    head   = {2'b00, frame[45:40], R1_STATUS};
                    reply  = {head, sd_pkg::crc7(head), 1'b1};
                    answer = 1'b1;
                end else if (!silent && frame[45:40] == sd_pkg::ACMD41_OP_COND) begin
                    // R3 has no CRC, all ones in its place
                    if (acmd41_cnt < busy_count)
                        reply = {2'b00, 6'h3f, BUSY_OCR, 7'h7f, 1'b1};
                    else
                        reply = {2'b00, 6'h3f, READY_OCR, 7'h7f, 1'b1};
                    acmd41_cnt++;
                    answer = 1'b1;
                end

                // response goes out on falls, host samples on rises
                if (answer) begin
                    delay = 2 + ({$random(seed)} % 7);
                    repeat (delay) @(negedge sd_clk);
                    for (int i = 47; i >= 0; i--) begin
                        cmd_in = reply[i];
                        @(negedge sd_clk);
                    end
                    cmd_in = 1'b1;
                end
            end
        end
    end

endmodule

/* tb/tb_sd_init.sv */
// testbench for the SD initializer against the behavioural card
// short divider and retry limit keep the runs small
// every scenario starts from a fresh reset
`timescale 1ns/1ns

module tb_sd_init;

    localparam int          CLK_DIV      = 4;
    localparam int          RESP_TIMEOUT = 64;
    localparam int          MAX_RETRIES  = 5;
    localparam logic [31:0] CARD_OCR     = 32'hc0ff_8000;
    localparam int          RUN_LIMIT    = 40000;
    localparam int          CHAR_LIMIT   = 1000;
    // reference frames with their CRC7 bytes
    localparam logic [47:0] CMD0_FRAME   = 48'h40_0000_0000_95;
    localparam logic [47:0] CMD55_FRAME  = 48'h77_0000_0000_65;
    localparam logic [47:0] ACMD41_FRAME = 48'h69_4000_0000_77;

    logic clk, rst_n, cmd_in, sd_clk, cmd_out, cmd_oe;
    logic char_valid, init_done, init_error, silent;
    logic [7:0]  char_data;
    logic [31:0] ocr;
    logic [47:0] last_cmd;
    logic        cmd_toggle, toggle_q, crc_error;
    int          busy_count, char_idx, frame_idx;
    // line monitor state
    int          hist_cnt, run_len, pre_rises;
    logic        first_run, oe_seen, pre_done;
    logic        sd_clk_q, sd_clk_q2, cmd_out_q;

    sd_init_top #(
        .CLK_DIV      (CLK_DIV),
        .RESP_TIMEOUT (RESP_TIMEOUT),
        .MAX_RETRIES  (MAX_RETRIES)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_in     (cmd_in),
        .sd_clk     (sd_clk),
        .cmd_out    (cmd_out),
        .cmd_oe     (cmd_oe),
        .char_valid (char_valid),
        .init_done  (init_done),
        .init_error (init_error),
        .char_data  (char_data),
        .ocr        (ocr)
    );

    sd_card_model #(
        .READY_OCR (CARD_OCR)
    ) card (
        .sd_clk     (sd_clk),
        .cmd_out    (cmd_out),
        .cmd_oe     (cmd_oe),
        .busy_count (busy_count),
        .silent     (silent),
        .cmd_in     (cmd_in),
        .last_cmd   (last_cmd),
        .cmd_toggle (cmd_toggle),
        .crc_error  (crc_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // reference model of the status stream
    // ========================================
    function automatic int expected_pairs(input int busy);
        return (busy < MAX_RETRIES) ? busy + 1 : MAX_RETRIES;
    endfunction

    function automatic int expected_count(input int busy, input logic quiet);
        return quiet ? 2 : 2 * expected_pairs(busy) + 2;
    endfunction

    function automatic sd_pkg::status_char_t expected_char(input int busy, input logic quiet,
                                                           input int pos);
        if (pos == 0)
            return sd_pkg::CH_CMD0;
        if (quiet)
            return sd_pkg::CH_TIMEOUT;
        if (pos == expected_count(busy, quiet) - 1)
            return (busy < MAX_RETRIES) ? sd_pkg::CH_DONE : sd_pkg::CH_RETRY_LIMIT;
        return pos[0] ? sd_pkg::CH_CMD55 : sd_pkg::CH_ACMD41;
    endfunction

    // CMD0 first, then CMD55 and ACMD41 alternate
    function automatic logic [47:0] expected_frame(input int idx);
        if (idx == 0)
            return CMD0_FRAME;
        return idx[0] ? CMD55_FRAME : ACMD41_FRAME;
    endfunction

    // ========================================
    // failure reporting and compares
    // ========================================
    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_char(input sd_pkg::status_char_t actual,
                              input sd_pkg::status_char_t expected);
        if (actual !== expected)
            report_error($sformatf("status char %0d is '%c', expected '%c'",
                                   char_idx, actual, expected));
    endtask

    task automatic check_ocr(input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected)
            report_error($sformatf("ocr %h, expected %h", actual, expected));
    endtask

    task automatic check_frame(input logic [47:0] actual, input logic [47:0] expected);
        if (actual !== expected)
            report_error($sformatf("command frame %0d is %h, expected %h",
                                   frame_idx, actual, expected));
    endtask

    task automatic check_level(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            report_error($sformatf("%s is %b, expected %b", what, actual, expected));
    endtask

    // ========================================
    // monitors, sampled on the rising clock
    // ========================================
    always @(posedge clk) begin
        if (rst_n && char_valid) begin
            if (char_idx >= expected_count(busy_count, silent))
                report_error($sformatf("extra status char '%c'", char_data));
            else
                check_char(char_data, expected_char(busy_count, silent, char_idx));
            char_idx++;
        end
    end

    always @(posedge clk) begin
        if (crc_error)
            abort_run("the card model rejected a command frame");
        if (cmd_toggle != toggle_q) begin
            toggle_q = cmd_toggle;
            if (rst_n) begin
                // idle clocks are complete once the first frame is in
                if (frame_idx == 0 && pre_rises != 80)
                    report_error($sformatf("%0d idle clocks before CMD0, expected 80",
                                           pre_rises));
                check_frame(last_cmd, expected_frame(frame_idx));
                frame_idx++;
            end
        end
    end

    // sd_clk phases, cmd_out edges and the idle clocks
    always @(posedge clk) begin
        if (!rst_n) begin
            hist_cnt  = 0;
            run_len   = 0;
            first_run = 1'b1;
            oe_seen   = 1'b0;
            pre_done  = 1'b0;
            pre_rises = 0;
        end else begin
            // cmd_out moves one clock after the fall strobe
            if (hist_cnt >= 2 && cmd_out !== cmd_out_q && !(sd_clk_q2 && !sd_clk_q && !sd_clk))
                report_error("cmd_out changed away from an sd_clk falling edge");
            if (hist_cnt >= 1) begin
                if (sd_clk == sd_clk_q) begin
                    run_len++;
                end else begin
                    if (!first_run && run_len != CLK_DIV)
                        report_error($sformatf("sd_clk phase of %0d clocks, expected %0d",
                                               run_len, CLK_DIV));
                    first_run = 1'b0;
                    run_len   = 1;
                end
            end
            if (cmd_oe)
                oe_seen = 1'b1;
            if (oe_seen && !pre_done && sd_clk && !sd_clk_q) begin
                if (cmd_out) begin
                    check_level(cmd_oe, 1'b1, "cmd_oe during idle clocks");
                    pre_rises++;
                end else begin
                    pre_done = 1'b1;
                end
            end
            hist_cnt++;
        end
        sd_clk_q2 = sd_clk_q;
        sd_clk_q  = sd_clk;
        cmd_out_q = cmd_out;
    end

    // ========================================
    // scenarios
    // ========================================
    task automatic run_scenario(input int busy, input logic quiet, input string name);
        int wait_cnt;
        int frames;
        $display("scenario: %s", name);
        @(negedge clk);
        busy_count = busy;
        silent     = quiet;
        rst_n      = 1'b0;
        char_idx   = 0;
        frame_idx  = 0;
        repeat (3) @(negedge clk);
        rst_n    = 1'b1;
        wait_cnt = 0;
        while (!init_done && !init_error) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > RUN_LIMIT)
                abort_run($sformatf("timeout: %s never finished", name));
        end
        wait_cnt = 0;
        while (char_idx < expected_count(busy, quiet)) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > CHAR_LIMIT)
                abort_run($sformatf("timeout: status chars missing in %s", name));
        end
        frames = quiet ? 2 : 2 * expected_pairs(busy) + 1;
        if (frame_idx != frames)
            report_error($sformatf("%0d command frames, expected %0d", frame_idx, frames));
        if (!quiet && busy < MAX_RETRIES) begin
            check_level(init_done, 1'b1, "init_done");
            check_level(init_error, 1'b0, "init_error");
            check_ocr(ocr, CARD_OCR);
        end else begin
            check_level(init_error, 1'b1, "init_error");
            check_level(init_done, 1'b0, "init_done");
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        silent     = 1'b0;
        busy_count = 0;
        char_idx   = 0;
        frame_idx  = 0;
        toggle_q   = 1'b0;
        run_scenario(0, 1'b0, "card ready at once");
        run_scenario(3, 1'b0, "card busy three times");
        run_scenario(MAX_RETRIES + 2, 1'b0, "card busy past the retry limit");
        run_scenario(0, 1'b1, "card silent");
        $display("Test OK");
        $finish;
    end

endmodule
